// ==== Makefile ====
SIM     = obj_dir/Vtb_poly_fios_control
SOURCES = filelist.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	verilator --binary -Wno-fatal --top-module tb_poly_fios_control -f filelist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
+incdir+rtl
rtl/fios_pkg.sv
rtl/loop_ctrl_if.sv
rtl/fios_phase_fsm.sv
rtl/fios_loop_counters.sv
rtl/fios_control_decode.sv
rtl/poly_fios_control.sv
sim/tb_poly_fios_control.sv

// ==== rtl/fios_control_decode.sv ====
module fios_control_decode (
    input  logic                  clock_i,
    input  fios_pkg::fios_state_t state_i,
    input  logic                  word_last_i,
    output logic                  a_rot_o,
    output logic                  b_shift_o,
    output logic                  b_rot_o,
    output logic                  b_reg_en_o,
    output logic                  m_prime_rot_o,
    output logic                  m_shift_o,
    output logic                  c_high_en_o,
    output logic                  c_low_en_o,
    output logic                  c_low_sel_o,
    output logic                  q_reg_en_o,
    output logic                  q_sel_o,
    output logic                  dsp_creg_en_o,
    output logic                  temp_reg_en_o,
    output fios_pkg::mux_sel_t    mux_a_sel_o,
    output fios_pkg::mux_sel_t    mux_b_sel_o,
    output fios_pkg::mux_sel_t    mux_c_sel_o,
    output logic [8:0]            opmode_o,
    output logic                  signext_o,
    output logic                  done_o
);

    import fios_pkg::*;

    opmode_u opmode;
    logic    temp_en;

    // Multiply phases feed the multiplier output through both X and Y.
    function automatic opmode_u mul_opmode(input logic [1:0] w_sel, input logic [2:0] z_sel);
        opmode_u op;
        op.fields.w_sel = w_sel;
        op.fields.z_sel = z_sel;
        op.fields.y_sel = Y_M;
        op.fields.x_sel = X_M;
        return op;
    endfunction

    always_comb begin
        a_rot_o       = 1'b0;
        b_shift_o     = 1'b0;
        b_rot_o       = 1'b0;
        b_reg_en_o    = 1'b0;
        m_prime_rot_o = 1'b0;
        m_shift_o     = 1'b0;
        c_high_en_o   = 1'b0;
        c_low_en_o    = 1'b0;
        c_low_sel_o   = 1'b0;
        q_reg_en_o    = 1'b0;
        q_sel_o       = 1'b0;
        dsp_creg_en_o = 1'b0;
        temp_en       = 1'b0;
        mux_a_sel_o   = 2'd0;
        mux_b_sel_o   = 2'd0;
        mux_c_sel_o   = 2'd0;
        opmode.fields = '{w_sel: W_ZERO, z_sel: Z_ZERO, y_sel: Y_ZERO, x_sel: X_ZERO};
        done_o        = 1'b0;

        case (state_i)
            IDLE: begin
                b_shift_o           = 1'b1;
                b_reg_en_o          = 1'b1;
                opmode.fields.z_sel = Z_P;
            end
            MUL_A0_B0, MUL_A0_B1, MUL_A_B: begin
                a_rot_o = 1'b1;
                b_rot_o = 1'b1;
                opmode  = mul_opmode(W_P, Z_ZERO);
            end
            MUL_A0_B0_END, MUL_A0_B1_END: begin
                a_rot_o    = 1'b1;
                b_reg_en_o = 1'b1;
                opmode     = mul_opmode(W_P, Z_ZERO);
            end
            TEMP0: begin
                a_rot_o   = 1'b1;
                b_shift_o = 1'b1;
                b_rot_o   = 1'b1;
                opmode    = mul_opmode(W_ZERO, Z_ZERO);
            end
            // C0 is captured whole here; later beats refill only the low half.
            MUL_MP0_C0_BEGIN: begin
                m_prime_rot_o = 1'b1;
                c_high_en_o   = 1'b1;
                c_low_en_o    = 1'b1;
                temp_en       = 1'b1;
                mux_a_sel_o   = 2'd1;
                mux_b_sel_o   = 2'd1;
                opmode        = mul_opmode(W_ZERO, Z_ZERO);
            end
            MUL_MP0_C0, MUL_MP0_C0_END: begin
                m_prime_rot_o = 1'b1;
                c_low_en_o    = 1'b1;
                c_low_sel_o   = 1'b1;
                dsp_creg_en_o = (state_i == MUL_MP0_C0_END);
                mux_a_sel_o   = 2'd1;
                mux_b_sel_o   = 2'd2;
                opmode        = mul_opmode(W_P, Z_ZERO);
            end
            TEMP1: begin
                a_rot_o = 1'b1;
                b_rot_o = 1'b1;
                opmode  = mul_opmode(W_C, Z_ZERO);
            end
            MUL_M0_Q_BEGIN: begin
                m_shift_o     = 1'b1;
                q_reg_en_o    = 1'b1;
                temp_en       = 1'b1;
                dsp_creg_en_o = 1'b1;
                mux_a_sel_o   = 2'd2;
                mux_b_sel_o   = 2'd1;
                mux_c_sel_o   = 2'd1;
                opmode        = mul_opmode(W_C, Z_ZERO);
            end
            MUL_M0_Q, MUL_M0_Q_END, MUL_M1_Q,
            MUL_M1_Q_END, MUL_M_Q, MUL_M_Q_END: begin
                m_shift_o   = 1'b1;
                q_reg_en_o  = 1'b1;
                q_sel_o     = 1'b1;
                b_reg_en_o  = (state_i == MUL_M_Q_END);
                mux_a_sel_o = 2'd2;
                mux_b_sel_o = 2'd3;
                opmode      = mul_opmode(W_P, Z_ZERO);
            end
            // Word 1 starts from the shifted carry plus the stored C value.
            MUL_A0_B1_BEGIN: begin
                a_rot_o       = 1'b1;
                b_rot_o       = 1'b1;
                dsp_creg_en_o = 1'b1;
                opmode        = mul_opmode(W_C, Z_P_SHIFT);
            end
            MUL_A_B_BEGIN: begin
                a_rot_o = 1'b1;
                b_rot_o = 1'b1;
                opmode  = mul_opmode(W_ZERO, Z_P_SHIFT);
            end
            MUL_A_B_END: begin
                a_rot_o   = 1'b1;
                b_shift_o = 1'b1;
                opmode    = mul_opmode(W_P, Z_ZERO);
            end
            SHIFT: begin
                opmode.fields.z_sel = Z_P_SHIFT;
            end
            DONE: begin
                done_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // TEMP loads one cycle after the phase that selects it, when P is valid.
    always_ff @(posedge clock_i) begin
        temp_reg_en_o <= temp_en;
    end

    assign opmode_o  = opmode.raw;
    assign signext_o = word_last_i;

endmodule

// ==== rtl/fios_loop_counters.sv ====
`include "fios_settings.svh"

module fios_loop_counters (
    input logic           clock_i,
    loop_ctrl_if.counters loop
);

    logic [`FIOS_WORD_W-1:0] word_count;

    // Beats within the current word product.
    always_ff @(posedge clock_i) begin
        if (loop.beat_clear) begin
            loop.beat_count <= '0;
        end else if (loop.beat_step) begin
            loop.beat_count <= loop.beat_count + 1'b1;
        end
    end

    // Outer FIOS iterations, one per M*q reduction.
    always_ff @(posedge clock_i) begin
        if (loop.word_clear) begin
            word_count <= '0;
        end else if (loop.word_step) begin
            word_count <= word_count + 1'b1;
        end
    end

    assign loop.word_last = (word_count == `FIOS_WORD_W'(`FIOS_WORDS - 1));

endmodule

// ==== rtl/fios_phase_fsm.sv ====
`include "fios_settings.svh"

module fios_phase_fsm (
    input  logic                  clock_i,
    input  logic                  inner_loop_counter_reset,
    input  logic                  start_i,
    loop_ctrl_if.fsm              loop,
    output fios_pkg::fios_state_t state_o
);

    import fios_pkg::*;

    fios_state_t state;
    fios_state_t state_next;
    logic        beat_end;
    logic        beat_end_b1;

    // A product phase ends two beats before N. The A0*B1 product overlaps
    // the tail of M0*q, so it ends two beats earlier still.
    assign beat_end    = (loop.beat_count == `FIOS_BEAT_W'(`FIOS_MUL_CYCLES - 2));
    assign beat_end_b1 = (loop.beat_count == `FIOS_BEAT_W'(`FIOS_MUL_CYCLES - 4));

    always_ff @(posedge clock_i) begin
        if (inner_loop_counter_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign state_o = state;

    // The beat counter runs through every product phase and is cleared
    // in all the other phases.
    assign loop.beat_step = state inside {
        MUL_A0_B0,
        MUL_MP0_C0_BEGIN,
        MUL_MP0_C0,
        MUL_M0_Q_BEGIN,
        MUL_M0_Q,
        MUL_A0_B1_BEGIN,
        MUL_A0_B1,
        MUL_M1_Q,
        MUL_A_B_BEGIN,
        MUL_A_B,
        MUL_M_Q
    };
    assign loop.beat_clear = ~loop.beat_step;

    // One word step per reduction except the last, so the count reaches
    // s-1 at the start of the final loop pass and holds through SHIFT.
    assign loop.word_step  = (state inside {MUL_M0_Q_END, MUL_M1_Q_END})
                             || ((state == MUL_M_Q_END) && !loop.word_last);
    assign loop.word_clear = state inside {IDLE, SHIFT};

    always_comb begin
        case (state)
            IDLE:             state_next = start_i ? MUL_A0_B0 : IDLE;
            MUL_A0_B0:        state_next = beat_end ? MUL_A0_B0_END : MUL_A0_B0;
            MUL_A0_B0_END:    state_next = TEMP0;
            TEMP0:            state_next = MUL_MP0_C0_BEGIN;
            MUL_MP0_C0_BEGIN: state_next = MUL_MP0_C0;
            MUL_MP0_C0:       state_next = beat_end ? MUL_MP0_C0_END : MUL_MP0_C0;
            MUL_MP0_C0_END:   state_next = TEMP1;
            TEMP1:            state_next = MUL_M0_Q_BEGIN;
            MUL_M0_Q_BEGIN:   state_next = MUL_M0_Q;
            MUL_M0_Q:         state_next = beat_end ? MUL_M0_Q_END : MUL_M0_Q;
            MUL_M0_Q_END:     state_next = MUL_A0_B1_BEGIN;
            MUL_A0_B1_BEGIN,
            MUL_A0_B1:        state_next = beat_end_b1 ? MUL_A0_B1_END : MUL_A0_B1;
            MUL_A0_B1_END:    state_next = MUL_M1_Q;
            MUL_M1_Q:         state_next = beat_end ? MUL_M1_Q_END : MUL_M1_Q;
            MUL_M1_Q_END:     state_next = MUL_A_B_BEGIN;
            MUL_A_B_BEGIN:    state_next = MUL_A_B;
            MUL_A_B:          state_next = beat_end ? MUL_A_B_END : MUL_A_B;
            MUL_A_B_END:      state_next = MUL_M_Q;
            MUL_M_Q:          state_next = beat_end ? MUL_M_Q_END : MUL_M_Q;
            // The last pass is the one that began with word_last already high.
            MUL_M_Q_END:      state_next = loop.word_last ? SHIFT : MUL_A_B_BEGIN;
            SHIFT:            state_next = DONE;
            DONE:             state_next = IDLE;
            default:          state_next = IDLE;
        endcase
    end

endmodule

// ==== rtl/fios_pkg.sv ====
package fios_pkg;

    // Phases of one FIOS Montgomery multiplication, in sequence order.
    typedef enum logic [4:0] {
        IDLE,
        MUL_A0_B0,
        MUL_A0_B0_END,
        TEMP0,
        MUL_MP0_C0_BEGIN,
        MUL_MP0_C0,
        MUL_MP0_C0_END,
        TEMP1,
        MUL_M0_Q_BEGIN,
        MUL_M0_Q,
        MUL_M0_Q_END,
        MUL_A0_B1_BEGIN,
        MUL_A0_B1,
        MUL_A0_B1_END,
        MUL_M1_Q,
        MUL_M1_Q_END,
        MUL_A_B_BEGIN,
        MUL_A_B,
        MUL_A_B_END,
        MUL_M_Q,
        MUL_M_Q_END,
        SHIFT,
        DONE
    } fios_state_t;

    typedef logic [1:0] mux_sel_t;

    // DSP OPMODE word, split into its W, Z, Y and X multiplexer selects.
    typedef struct packed {
        logic [1:0] w_sel;
        logic [2:0] z_sel;
        logic [1:0] y_sel;
        logic [1:0] x_sel;
    } opmode_fields_t;

    typedef union packed {
        logic [8:0]     raw;
        opmode_fields_t fields;
    } opmode_u;

    localparam logic [1:0] X_ZERO    = 2'b00;
    localparam logic [1:0] X_M       = 2'b01;
    localparam logic [1:0] Y_ZERO    = 2'b00;
    localparam logic [1:0] Y_M       = 2'b01;
    localparam logic [2:0] Z_ZERO    = 3'b000;
    localparam logic [2:0] Z_P       = 3'b010;
    // P shifted right by 17, the carry into the next word.
    localparam logic [2:0] Z_P_SHIFT = 3'b110;
    localparam logic [1:0] W_ZERO    = 2'b00;
    localparam logic [1:0] W_P       = 2'b01;
    localparam logic [1:0] W_C       = 2'b11;

endpackage

// ==== rtl/fios_settings.svh ====
`ifndef FIOS_SETTINGS_SVH
`define FIOS_SETTINGS_SVH

// Number of words s in each operand, 3 or more.
`define FIOS_WORDS 4

// Number of DSP beats N per word product, 4 or more.
`define FIOS_MUL_CYCLES 5

// Counter widths follow from the two sizes above.
`define FIOS_BEAT_W ($clog2(`FIOS_MUL_CYCLES + 1))
`define FIOS_WORD_W ($clog2(`FIOS_WORDS + 1))

`endif

// ==== rtl/loop_ctrl_if.sv ====
`include "fios_settings.svh"

interface loop_ctrl_if;

    logic                    beat_clear;
    logic                    beat_step;
    logic                    word_clear;
    logic                    word_step;
    logic [`FIOS_BEAT_W-1:0] beat_count;
    logic                    word_last;

    modport fsm (
        output beat_clear,
        output beat_step,
        output word_clear,
        output word_step,
        input  beat_count,
        input  word_last
    );

    modport counters (
        input  beat_clear,
        input  beat_step,
        input  word_clear,
        input  word_step,
        output beat_count,
        output word_last
    );

endinterface

// ==== rtl/poly_fios_control.sv ====
module poly_fios_control (
    input  logic               clock_i,
    input  logic               inner_loop_counter_reset,
    input  logic               start_i,
    output logic               a_rot_o,
    output logic               b_shift_o,
    output logic               b_rot_o,
    output logic               b_reg_en_o,
    output logic               m_prime_rot_o,
    output logic               m_shift_o,
    output logic               c_high_en_o,
    output logic               c_low_en_o,
    output logic               c_low_sel_o,
    output logic               q_reg_en_o,
    output logic               q_sel_o,
    output logic               dsp_creg_en_o,
    output logic               temp_reg_en_o,
    output fios_pkg::mux_sel_t mux_a_sel_o,
    output fios_pkg::mux_sel_t mux_b_sel_o,
    output fios_pkg::mux_sel_t mux_c_sel_o,
    output logic [8:0]         opmode_o,
    output logic               signext_o,
    output logic               done_o
);

    import fios_pkg::*;

    fios_state_t state;

    loop_ctrl_if loop ();

    fios_phase_fsm u_phase_fsm (
        .clock_i                  (clock_i),
        .inner_loop_counter_reset (inner_loop_counter_reset),
        .start_i                  (start_i),
        .loop                     (loop.fsm),
        .state_o                  (state)
    );

    fios_loop_counters u_loop_counters (
        .clock_i (clock_i),
        .loop    (loop.counters)
    );

    fios_control_decode u_control_decode (
        .clock_i       (clock_i),
        .state_i       (state),
        .word_last_i   (loop.word_last),
        .a_rot_o       (a_rot_o),
        .b_shift_o     (b_shift_o),
        .b_rot_o       (b_rot_o),
        .b_reg_en_o    (b_reg_en_o),
        .m_prime_rot_o (m_prime_rot_o),
        .m_shift_o     (m_shift_o),
        .c_high_en_o   (c_high_en_o),
        .c_low_en_o    (c_low_en_o),
        .c_low_sel_o   (c_low_sel_o),
        .q_reg_en_o    (q_reg_en_o),
        .q_sel_o       (q_sel_o),
        .dsp_creg_en_o (dsp_creg_en_o),
        .temp_reg_en_o (temp_reg_en_o),
        .mux_a_sel_o   (mux_a_sel_o),
        .mux_b_sel_o   (mux_b_sel_o),
        .mux_c_sel_o   (mux_c_sel_o),
        .opmode_o      (opmode_o),
        .signext_o     (signext_o),
        .done_o        (done_o)
    );

endmodule

// ==== sim/tb_poly_fios_control.sv ====
`include "fios_settings.svh"

module tb_poly_fios_control;

    localparam int N = `FIOS_MUL_CYCLES;
    localparam int S = `FIOS_WORDS;
    // Edges from the one that samples start_i to the one that opens DONE.
    localparam int LATENCY        = 5 * N + 2 * N * (S - 2) + 1;
    localparam int MAX_GAP        = 12;
    localparam int HOLD_RUNS      = 3;
    localparam int GAP_RUNS       = 4;
    localparam int TOTAL_RUNS     = 4 + HOLD_RUNS + GAP_RUNS;
    localparam int RESET_CYCLES   = 5;
    localparam int IDLE_CYCLES    = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES
                                    + TOTAL_RUNS * (LATENCY + MAX_GAP + 10);

    logic       clock_i = 1'b0;
    logic       inner_loop_counter_reset;
    logic       start_i;
    logic       a_rot_o;
    logic       b_shift_o;
    logic       b_rot_o;
    logic       b_reg_en_o;
    logic       m_prime_rot_o;
    logic       m_shift_o;
    logic       c_high_en_o;
    logic       c_low_en_o;
    logic       c_low_sel_o;
    logic       q_reg_en_o;
    logic       q_sel_o;
    logic       dsp_creg_en_o;
    logic       temp_reg_en_o;
    logic [1:0] mux_a_sel_o;
    logic [1:0] mux_b_sel_o;
    logic [1:0] mux_c_sel_o;
    logic [8:0] opmode_o;
    logic       signext_o;
    logic       done_o;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic [31:0] lcg_state = 32'h62a4;

    // What one run looked like, counted in edges after the start edge.
    int         done_cycle;
    int         done_width;
    logic [8:0] done_opmode;
    int         q_count;
    int         q_first;
    int         c_high_count;
    int         c_high_cycle;
    int         signext_runs;
    int         signext_len;
    int         signext_last;
    int         temp_cycles[$];

    poly_fios_control UUT (
        .clock_i                  (clock_i),
        .inner_loop_counter_reset (inner_loop_counter_reset),
        .start_i                  (start_i),
        .a_rot_o                  (a_rot_o),
        .b_shift_o                (b_shift_o),
        .b_rot_o                  (b_rot_o),
        .b_reg_en_o               (b_reg_en_o),
        .m_prime_rot_o            (m_prime_rot_o),
        .m_shift_o                (m_shift_o),
        .c_high_en_o              (c_high_en_o),
        .c_low_en_o               (c_low_en_o),
        .c_low_sel_o              (c_low_sel_o),
        .q_reg_en_o               (q_reg_en_o),
        .q_sel_o                  (q_sel_o),
        .dsp_creg_en_o            (dsp_creg_en_o),
        .temp_reg_en_o            (temp_reg_en_o),
        .mux_a_sel_o              (mux_a_sel_o),
        .mux_b_sel_o              (mux_b_sel_o),
        .mux_c_sel_o              (mux_c_sel_o),
        .opmode_o                 (opmode_o),
        .signext_o                (signext_o),
        .done_o                   (done_o)
    );

    always #50 clock_i = ~clock_i;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_idle_row();
        check_value("a_rot_o", a_rot_o, 0);
        check_value("b_shift_o", b_shift_o, 1);
        check_value("b_rot_o", b_rot_o, 0);
        check_value("b_reg_en_o", b_reg_en_o, 1);
        check_value("m_prime_rot_o", m_prime_rot_o, 0);
        check_value("m_shift_o", m_shift_o, 0);
        check_value("c_high_en_o", c_high_en_o, 0);
        check_value("c_low_en_o", c_low_en_o, 0);
        check_value("c_low_sel_o", c_low_sel_o, 0);
        check_value("q_reg_en_o", q_reg_en_o, 0);
        check_value("q_sel_o", q_sel_o, 0);
        check_value("dsp_creg_en_o", dsp_creg_en_o, 0);
        check_value("temp_reg_en_o", temp_reg_en_o, 0);
        check_value("mux_a_sel_o", mux_a_sel_o, 0);
        check_value("mux_b_sel_o", mux_b_sel_o, 0);
        check_value("mux_c_sel_o", mux_c_sel_o, 0);
        check_value("opmode_o", opmode_o, 9'h020);
        check_value("signext_o", signext_o, 0);
        check_value("done_o", done_o, 0);
    endtask

    // Starts one run from IDLE and records it until done_o falls again.
    task automatic run_once(input bit keep_start);
        bit prev_signext;
        check_value("opmode_o before start", opmode_o, 9'h020);
        start_i      = 1'b1;
        done_cycle   = -1;
        done_width   = 0;
        done_opmode  = '0;
        q_count      = 0;
        q_first      = -1;
        c_high_count = 0;
        c_high_cycle = -1;
        signext_runs = 0;
        signext_len  = 0;
        signext_last = -1;
        prev_signext = 1'b0;
        temp_cycles.delete();
        for (int cycle = 0; cycle <= LATENCY + 8; cycle++) begin
            @(negedge clock_i);
            start_i = keep_start;
            if (done_o) begin
                if (done_cycle < 0) begin
                    done_cycle  = cycle;
                    done_opmode = opmode_o;
                end
                done_width++;
            end else if (done_cycle >= 0) begin
                break;
            end
            if (q_reg_en_o) begin
                if (q_count == 0) begin
                    q_first = cycle;
                end
                q_count++;
            end
            if (c_high_en_o) begin
                c_high_count++;
                c_high_cycle = cycle;
            end
            if (temp_reg_en_o) begin
                temp_cycles.push_back(cycle);
            end
            if (signext_o) begin
                if (!prev_signext) begin
                    signext_runs++;
                end
                signext_len++;
                signext_last = cycle;
            end
            prev_signext = signext_o;
        end
        if (done_cycle < 0) begin
            report_error("done_o never rose after start_i was sampled");
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = errors;
        repeat (IDLE_CYCLES) begin
            @(negedge clock_i);
            check_idle_row();
        end
        end_test("reset state", errors_before);
    endtask

    task automatic test_latency();
        int errors_before;
        errors_before = errors;
        run_once(1'b0);
        check_value("done_o rise edge", done_cycle, LATENCY);
        check_value("done_o pulse width", done_width, 1);
        end_test("latency", errors_before);
    endtask

    task automatic test_product_counts();
        int errors_before;
        errors_before = errors;
        run_once(1'b0);
        check_value("q_reg_en_o cycles", q_count, N * S);
        check_value("c_high_en_o cycles", c_high_count, 1);
        check_value("opmode_o in done cycle", done_opmode, 0);
        end_test("product counts", errors_before);
    endtask

    task automatic test_temp_timing();
        int errors_before;
        errors_before = errors;
        run_once(1'b0);
        check_value("temp_reg_en_o pulses", temp_cycles.size(), 2);
        if (temp_cycles.size() == 2) begin
            check_value("temp_reg_en_o first pulse", temp_cycles[0], c_high_cycle + 1);
            check_value("temp_reg_en_o second pulse", temp_cycles[1], q_first + 1);
        end
        end_test("temp timing", errors_before);
    endtask

    // The flag covers the final A*B and M*q pass and the shift, 2N+1 cycles long.
    task automatic test_sign_extension();
        int errors_before;
        errors_before = errors;
        run_once(1'b0);
        check_value("signext_o high stretches", signext_runs, 1);
        check_value("signext_o high cycles", signext_len, 2 * N + 1);
        if (signext_last >= done_cycle) begin
            report_error("signext_o was still high when done_o rose");
        end
        end_test("sign extension", errors_before);
    endtask

    task automatic test_repeat_and_ignore();
        int errors_before;
        int gap;
        errors_before = errors;
        repeat (HOLD_RUNS) begin
            run_once(1'b1);
            check_value("done_o rise edge with start held", done_cycle, LATENCY);
            check_value("done_o pulse width with start held", done_width, 1);
        end
        start_i = 1'b0;
        repeat (GAP_RUNS) begin
            gap = int'((next_random() >> 16) % MAX_GAP) + 1;
            repeat (gap) begin
                @(negedge clock_i);
                check_value("done_o in idle gap", done_o, 0);
                check_value("opmode_o in idle gap", opmode_o, 9'h020);
            end
            run_once(1'b0);
            check_value("done_o rise edge after gap", done_cycle, LATENCY);
            check_value("done_o pulse width after gap", done_width, 1);
        end
        end_test("repeat and ignore", errors_before);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock_i);
        $display("Watchdog expired after %0d cycles before the tests ended", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        inner_loop_counter_reset = 1'b1;
        start_i                  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock_i);
        inner_loop_counter_reset = 1'b0;

        test_reset_state();
        test_latency();
        test_product_counts();
        test_temp_timing();
        test_sign_extension();
        test_repeat_and_ignore();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
